/* Makefile */
TOP  := tb_m72_cpu_glue
SIM  := obj_dir/V$(TOP)
SRCS := $(wildcard common/*.sv cpu_bus/*.sv hw/*.sv sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): m72_cpu_glue.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f m72_cpu_glue.f

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/m72_bus_pkg.sv */
// Shared widths, address map and bus structs for the M72 CPU glue; referenced by scoped name
`default_nettype none

package m72_bus_pkg;

    // ========================================
    // Widths with a meaning
    // ========================================
    typedef logic [19:0] cpu_addr_t;
    typedef logic [15:0] cpu_data_t;
    // Bit 0 enables the low byte
    typedef logic [1:0]  byte_sel_t;
    // SDRAM addresses count 16-bit words
    typedef logic [24:0] sdr_addr_t;
    typedef logic [7:0]  io_addr_t;
    typedef logic [7:0]  io_data_t;

    // ========================================
    // Address map
    // ========================================
    // Program ROM occupies CPU space below ROM_LIMIT
    localparam sdr_addr_t ROM_BASE  = 25'h000_0000;
    localparam sdr_addr_t RAM_BASE  = 25'h008_0000;
    localparam cpu_addr_t ROM_LIMIT = 20'h8_0000;
    // Work RAM is the 64 KB page 0xA0000-0xAFFFF
    localparam logic [3:0] RAM_PAGE = 4'hA;

    // I/O ports, always even; bit 0 picks the byte
    localparam io_addr_t PORT_SWITCHES = 8'h00;
    localparam io_addr_t PORT_FLAGS    = 8'h02;
    localparam io_addr_t PORT_DIP      = 8'h04;

    // Unmapped reads float high
    localparam cpu_data_t OPEN_BUS = 16'hFFFF;

    // CPU enable is CLK_32M divided by 4
    localparam int CE_DIV_BITS = 2;

    // ========================================
    // Bus structs
    // ========================================
    // Memory cycle as driven by the CPU
    typedef struct packed {
        logic      read;
        logic      write;
        cpu_addr_t addr;
        cpu_data_t data;
        byte_sel_t sel;
    } cpu_mem_bus_t;

    // Word-aligned command handed to the SDRAM bridge
    typedef struct packed {
        sdr_addr_t sdr_addr;
        cpu_data_t data;
        byte_sel_t wr_sel;
        logic      writable;
        logic      odd;
        logic      mapped;
    } sdr_cmd_t;

    // Port I/O cycle as driven by the CPU
    typedef struct packed {
        logic     io_read;
        logic     io_write;
        io_addr_t io_addr;
        io_data_t io_dout;
    } io_bus_t;

    // Write-only system flags byte, coin0 in bit 0
    typedef struct packed {
        logic [1:0] unused;
        logic       bank;
        logic       brq_n;
        logic       cblk;
        logic       soft_nl_n;
        logic       coin1;
        logic       coin0;
    } sys_flags_t;

endpackage

`default_nettype wire

/* cpu_bus/cpu_bus_front.sv */
// CPU memory-cycle front end; spots new cycles, word-aligns them and maps them onto SDRAM
`timescale 1ns/10ps
`default_nettype none

module cpu_bus_front (
    input  wire logic                      CLK_32M,
    input  wire logic                      reset_n,
    input  wire m72_bus_pkg::cpu_mem_bus_t mem,
    output m72_bus_pkg::sdr_cmd_t          cmd,
    output logic                           new_cmd
);

    logic read_q;
    logic write_q;
    logic new_cycle;

    m72_bus_pkg::cpu_data_t word_data;
    m72_bus_pkg::byte_sel_t word_sel;
    m72_bus_pkg::sdr_addr_t rom_offset;
    m72_bus_pkg::sdr_addr_t ram_offset;
    logic                   is_rom;
    logic                   is_ram;
    m72_bus_pkg::sdr_cmd_t  next_cmd;

    // ========================================
    // Cycle detection
    // ========================================
    // Strobes are held for the whole access, so only the rising edge counts
    assign new_cycle = (mem.read & ~read_q) | (mem.write & ~write_q);

    always_ff @(posedge CLK_32M) begin
        if (!reset_n) begin
            read_q  <= 1'b0;
            write_q <= 1'b0;
            new_cmd <= 1'b0;
        end else begin
            read_q  <= mem.read;
            write_q <= mem.write;
            new_cmd <= new_cycle;
        end
    end

    // ========================================
    // Alignment and region decode
    // ========================================
    // Odd byte accesses ride on the high lane of the word
    assign word_data = mem.addr[0] ? {mem.data[7:0], mem.data[15:8]} : mem.data;
    assign word_sel  = mem.addr[0] ? {mem.sel[0], mem.sel[1]} : mem.sel;

    assign is_rom = (mem.addr < m72_bus_pkg::ROM_LIMIT);
    assign is_ram = (mem.addr[19:16] == m72_bus_pkg::RAM_PAGE);

    // Word offsets inside each region
    assign rom_offset = {6'd0, mem.addr[19:1]};
    assign ram_offset = {10'd0, mem.addr[15:1]};

    always_comb begin
        next_cmd          = '0;
        next_cmd.data     = word_data;
        next_cmd.odd      = mem.addr[0];
        next_cmd.writable = is_ram;
        next_cmd.mapped   = is_rom | is_ram;
        next_cmd.wr_sel   = mem.write ? word_sel : 2'b00;
        if (is_ram) begin
            next_cmd.sdr_addr = m72_bus_pkg::RAM_BASE + ram_offset;
        end else begin
            next_cmd.sdr_addr = m72_bus_pkg::ROM_BASE + rom_offset;
        end
    end

    // Command is held until the next cycle starts
    always_ff @(posedge CLK_32M) begin
        if (new_cycle) begin
            cmd <= next_cmd;
        end
    end

endmodule

`default_nettype wire

/* cpu_bus/sdram_req_bridge.sv */
// One-deep SDRAM request bridge on a req/ack toggle pair; returns the byte-steered read word
`timescale 1ns/10ps
`default_nettype none

module sdram_req_bridge (
    input  wire logic                   CLK_32M,
    input  wire logic                   reset_n,
    input  wire m72_bus_pkg::sdr_cmd_t  cmd,
    input  wire logic                   new_cmd,
    output m72_bus_pkg::sdr_addr_t      sdr_addr,
    output m72_bus_pkg::cpu_data_t      sdr_din,
    output m72_bus_pkg::byte_sel_t      sdr_wr_sel,
    output logic                        sdr_req,
    input  wire m72_bus_pkg::cpu_data_t sdr_dout,
    input  wire logic                   sdr_ack,
    output logic                        busy,
    output m72_bus_pkg::cpu_data_t      mem_din
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_DONE
    } state_t;

    state_t                 state;
    logic                   issue;
    logic                   ack_match;
    logic                   steer_odd;
    m72_bus_pkg::cpu_data_t rd_word;

    assign issue     = new_cmd & cmd.mapped;
    // Request is outstanding while req and ack differ
    assign ack_match = (sdr_ack == sdr_req);

    // ========================================
    // Request FSM
    // ========================================
    always_ff @(posedge CLK_32M) begin
        if (!reset_n) begin
            state   <= ST_IDLE;
            sdr_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (issue) begin
                        sdr_req <= ~sdr_req;
                        state   <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (ack_match) begin
                        state <= ST_DONE;
                    end
                end
                // One settle cycle before the CPU may run again
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Stall starts in the cycle the command arrives
    assign busy = (state != ST_IDLE) | issue;

    // ========================================
    // Command and read data
    // ========================================
    always_ff @(posedge CLK_32M) begin
        if (new_cmd && state == ST_IDLE) begin
            steer_odd <= cmd.odd & cmd.mapped;
            if (cmd.mapped) begin
                sdr_addr   <= cmd.sdr_addr;
                sdr_din    <= cmd.data;
                // ROM stays read-only, the write degrades to a read
                sdr_wr_sel <= cmd.writable ? cmd.wr_sel : 2'b00;
            end else begin
                rd_word <= m72_bus_pkg::OPEN_BUS;
            end
        end else if (state == ST_WAIT_ACK && ack_match) begin
            rd_word <= sdr_dout;
        end
    end

    // Odd byte comes back in the low lane
    assign mem_din = steer_odd ? {8'h00, rd_word[15:8]} : rd_word;

    // ========================================
    // Checks
    // ========================================
    // CPU must be frozen until the previous access has finished
    a_no_cmd_while_busy: assert property (
        @(posedge CLK_32M) disable iff (!reset_n)
        new_cmd && cmd.mapped |-> state == ST_IDLE
    ) else $error("mapped command arrived during an SDRAM access");

    // The SDRAM side may only answer a request that is outstanding
    a_ack_only_when_pending: assert property (
        @(posedge CLK_32M) disable iff (!reset_n)
        !$stable(sdr_ack) |-> $past(sdr_ack != sdr_req)
    ) else $error("sdr_ack toggled with no request outstanding");

endmodule

`default_nettype wire

/* hw/cpu_clock_enable.sv */
// CPU clock enables from CLK_32M; both stop while an SDRAM access holds the stall input
`timescale 1ns/10ps
`default_nettype none

module cpu_clock_enable (
    input  wire logic CLK_32M,
    input  wire logic reset_n,
    input  wire logic stall,
    output logic      cpu_ce,
    output logic      cpu_ce_4x
);

    logic [m72_bus_pkg::CE_DIV_BITS-1:0] div_cnt;

    // Divider only advances on unstalled clocks, so no CPU phase is lost
    always_ff @(posedge CLK_32M) begin
        if (!reset_n) begin
            div_cnt   <= '0;
            cpu_ce    <= 1'b0;
            cpu_ce_4x <= 1'b0;
        end else begin
            cpu_ce    <= 1'b0;
            cpu_ce_4x <= 1'b0;
            if (!stall) begin
                div_cnt   <= div_cnt + 1'b1;
                cpu_ce_4x <= 1'b1;
                // Pulse on the wrap of the divider
                cpu_ce    <= &div_cnt;
            end
        end
    end

    // ========================================
    // Checks
    // ========================================
    // CPU steps stay at least four clocks apart, stalled or not
    a_ce_spacing: assert property (
        @(posedge CLK_32M) disable iff (!reset_n)
        cpu_ce |-> !$past(cpu_ce) && !$past(cpu_ce, 2) && !$past(cpu_ce, 3)
    ) else $error("cpu_ce pulses closer than four clocks apart");

endmodule

`default_nettype wire

/* hw/m72_cpu_glue.sv */
// Top level of the M72 main-CPU bus glue; connects CPU buses, SDRAM port and system I/O
`timescale 1ns/10ps
`default_nettype none

module m72_cpu_glue (
    input  wire logic                      CLK_32M,
    input  wire logic                      reset_n,
    // CPU memory and I/O buses
    input  wire m72_bus_pkg::cpu_mem_bus_t mem,
    output m72_bus_pkg::cpu_data_t         mem_din,
    input  wire m72_bus_pkg::io_bus_t      io,
    output m72_bus_pkg::io_data_t          io_din,
    output logic                           cpu_ce,
    output logic                           cpu_ce_4x,
    // Player and board inputs
    input  wire m72_bus_pkg::cpu_data_t    switches,
    input  wire logic [1:0]                coin,
    input  wire logic [1:0]                start_buttons,
    input  wire m72_bus_pkg::cpu_data_t    dip_sw,
    output logic [1:0]                     coin_count,
    output logic                           flip,
    output logic                           video_blank,
    // SDRAM CPU port
    output m72_bus_pkg::sdr_addr_t         sdr_addr,
    output m72_bus_pkg::cpu_data_t         sdr_din,
    output m72_bus_pkg::byte_sel_t         sdr_wr_sel,
    output logic                           sdr_req,
    input  wire m72_bus_pkg::cpu_data_t    sdr_dout,
    input  wire logic                      sdr_ack
);

    m72_bus_pkg::sdr_cmd_t cmd;
    logic                  new_cmd;
    logic                  busy;

    // CPU is held while the bridge has an access in flight
    cpu_clock_enable u_ce (
        .CLK_32M   (CLK_32M),
        .reset_n   (reset_n),
        .stall     (busy),
        .cpu_ce    (cpu_ce),
        .cpu_ce_4x (cpu_ce_4x)
    );

    cpu_bus_front u_front (
        .CLK_32M (CLK_32M),
        .reset_n (reset_n),
        .mem     (mem),
        .cmd     (cmd),
        .new_cmd (new_cmd)
    );

    sdram_req_bridge u_bridge (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .cmd        (cmd),
        .new_cmd    (new_cmd),
        .sdr_addr   (sdr_addr),
        .sdr_din    (sdr_din),
        .sdr_wr_sel (sdr_wr_sel),
        .sdr_req    (sdr_req),
        .sdr_dout   (sdr_dout),
        .sdr_ack    (sdr_ack),
        .busy       (busy),
        .mem_din    (mem_din)
    );

    sys_io_ports u_io (
        .CLK_32M       (CLK_32M),
        .reset_n       (reset_n),
        .io            (io),
        .switches      (switches),
        .coin          (coin),
        .start_buttons (start_buttons),
        .dip_sw        (dip_sw),
        .io_din        (io_din),
        .coin_count    (coin_count),
        .flip          (flip),
        .video_blank   (video_blank)
    );

endmodule

`default_nettype wire

/* hw/sys_io_ports.sv */
// System I/O ports; switch, flag and DIP reads plus the system-flags write with its outputs
`timescale 1ns/10ps
`default_nettype none

module sys_io_ports (
    input  wire logic                   CLK_32M,
    input  wire logic                   reset_n,
    input  wire m72_bus_pkg::io_bus_t   io,
    input  wire m72_bus_pkg::cpu_data_t switches,
    input  wire logic [1:0]             coin,
    input  wire logic [1:0]             start_buttons,
    input  wire m72_bus_pkg::cpu_data_t dip_sw,
    output m72_bus_pkg::io_data_t       io_din,
    output logic [1:0]                  coin_count,
    output logic                        flip,
    output logic                        video_blank
);

    m72_bus_pkg::cpu_data_t   flags;
    m72_bus_pkg::cpu_data_t   port_word;
    m72_bus_pkg::io_addr_t    even_addr;
    m72_bus_pkg::sys_flags_t  sys_flags;

    // ========================================
    // Read side
    // ========================================
    // Test, service and sprite-ready lines read back as idle ones
    assign flags     = {8'hFF, 4'hF, coin, start_buttons};
    assign even_addr = {io.io_addr[7:1], 1'b0};

    always_comb begin
        case (even_addr)
            m72_bus_pkg::PORT_SWITCHES: port_word = switches;
            m72_bus_pkg::PORT_FLAGS:    port_word = flags;
            m72_bus_pkg::PORT_DIP:      port_word = dip_sw;
            default:                    port_word = 16'hFFFF;
        endcase
    end

    // Odd port returns the high byte
    assign io_din = io.io_addr[0] ? port_word[15:8] : port_word[7:0];

    // ========================================
    // System flags
    // ========================================
    always_ff @(posedge CLK_32M) begin
        if (!reset_n) begin
            sys_flags <= '0;
        end else if (io.io_write && io.io_addr == m72_bus_pkg::PORT_FLAGS) begin
            sys_flags <= m72_bus_pkg::sys_flags_t'(io.io_dout);
        end
    end

    assign coin_count  = {sys_flags.coin1, sys_flags.coin0};
    // Screen flip is software flag combined with the DIP flip switch
    assign flip        = ~sys_flags.soft_nl_n ^ dip_sw[8];
    assign video_blank = sys_flags.cblk;

endmodule

`default_nettype wire

/* m72_cpu_glue.f */
common/m72_bus_pkg.sv
hw/cpu_clock_enable.sv
cpu_bus/cpu_bus_front.sv
cpu_bus/sdram_req_bridge.sv
hw/sys_io_ports.sv
hw/m72_cpu_glue.sv
sim/tb_clock_gen.sv
sim/tb_m72_cpu_glue.sv

/* sim/tb_clock_gen.sv */
// Testbench clock and reset source; CLK_32M with a 4 ns period, reset_n held low for 5 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic CLK_32M,
    output logic reset_n
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES   = 5;

    initial begin
        CLK_32M = 1'b0;
        forever #(HALF_PERIOD_NS) CLK_32M = ~CLK_32M;
    end

    // Release lands 1 ns after an edge, like the rest of the stimulus
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK_32M);
        #1;
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_m72_cpu_glue.sv */
// Testbench for the M72 CPU glue; plays the CPU, models SDRAM and runs a table of bus operations
`timescale 1ns/10ps
`default_nettype none

module tb_m72_cpu_glue;

    localparam int CLK_PERIOD_NS = 4;
    localparam int NUM_ROWS      = 21;
    localparam int IDLE_CLKS     = 32;
    localparam int WATCHDOG_CLKS = NUM_ROWS * 200 + IDLE_CLKS + 20;

    localparam logic [1:0] OP_MEM_RD = 2'd0;
    localparam logic [1:0] OP_MEM_WR = 2'd1;
    localparam logic [1:0] OP_IO_RD  = 2'd2;
    localparam logic [1:0] OP_IO_WR  = 2'd3;

    // Board inputs; DIP bit 8 is set so flip is inverted
    localparam m72_bus_pkg::cpu_data_t SWITCHES = 16'h3C96;
    localparam m72_bus_pkg::cpu_data_t DIP_SW   = 16'hFDE7;
    localparam logic [1:0]             COIN     = 2'b10;
    localparam logic [1:0]             START    = 2'b01;

    // One bus operation; word is the SDRAM word behind a memory access
    typedef struct packed {
        logic [1:0]             kind;
        m72_bus_pkg::cpu_addr_t addr;
        m72_bus_pkg::cpu_data_t data;
        m72_bus_pkg::byte_sel_t sel;
        m72_bus_pkg::sdr_addr_t word;
        logic [1:0]             reqs;
        m72_bus_pkg::cpu_data_t exp_val;
    } row_t;

    logic                      CLK_32M;
    logic                      reset_n;
    m72_bus_pkg::cpu_mem_bus_t mem;
    m72_bus_pkg::cpu_data_t    mem_din;
    m72_bus_pkg::io_bus_t      io;
    m72_bus_pkg::io_data_t     io_din;
    m72_bus_pkg::cpu_data_t    dip_sw;
    logic                      cpu_ce;
    logic                      cpu_ce_4x;
    logic [1:0]                coin_count;
    logic                      flip;
    logic                      video_blank;
    m72_bus_pkg::sdr_addr_t    sdr_addr;
    m72_bus_pkg::cpu_data_t    sdr_din;
    m72_bus_pkg::byte_sel_t    sdr_wr_sel;
    logic                      sdr_req;
    m72_bus_pkg::cpu_data_t    sdr_dout;
    logic                      sdr_ack;

    row_t   table_rows [NUM_ROWS];
    int     rows_loaded = 0;
    int     checks_run = 0;
    int     errors = 0;
    int     req_count = 0;
    integer seed = 32'h7cd5_9c2d;
    m72_bus_pkg::cpu_data_t sdram_mem [m72_bus_pkg::sdr_addr_t];

    tb_clock_gen u_clk (
        .CLK_32M (CLK_32M),
        .reset_n (reset_n)
    );

    m72_cpu_glue u_m72_cpu_glue (
        .CLK_32M       (CLK_32M),
        .reset_n       (reset_n),
        .mem           (mem),
        .mem_din       (mem_din),
        .io            (io),
        .io_din        (io_din),
        .cpu_ce        (cpu_ce),
        .cpu_ce_4x     (cpu_ce_4x),
        .switches      (SWITCHES),
        .coin          (COIN),
        .start_buttons (START),
        .dip_sw        (dip_sw),
        .coin_count    (coin_count),
        .flip          (flip),
        .video_blank   (video_blank),
        .sdr_addr      (sdr_addr),
        .sdr_din       (sdr_din),
        .sdr_wr_sel    (sdr_wr_sel),
        .sdr_req       (sdr_req),
        .sdr_dout      (sdr_dout),
        .sdr_ack       (sdr_ack)
    );

    // ========================================
    // SDRAM model
    // ========================================
    // Unwritten words read back a pattern of their whole address
    function automatic m72_bus_pkg::cpu_data_t fill_word(input m72_bus_pkg::sdr_addr_t a);
        return a[15:0] ^ {a[24:16], a[22:16]};
    endfunction

    function automatic m72_bus_pkg::cpu_data_t model_word(input m72_bus_pkg::sdr_addr_t a);
        if (sdram_mem.exists(a)) begin
            return sdram_mem[a];
        end
        return fill_word(a);
    endfunction

    // Answers each req toggle after 1 to 8 clocks
    initial begin : sdram_model
        int                     delay;
        m72_bus_pkg::cpu_data_t word;
        forever begin
            @(posedge CLK_32M);
            #1;
            if (reset_n && sdr_req != sdr_ack) begin
                req_count++;
                delay = 1 + int'($unsigned($random(seed)) % 32'd8);
                repeat (delay) @(posedge CLK_32M);
                #1;
                word = model_word(sdr_addr);
                if (sdr_wr_sel[0]) begin
                    word[7:0] = sdr_din[7:0];
                end
                if (sdr_wr_sel[1]) begin
                    word[15:8] = sdr_din[15:8];
                end
                if (sdr_wr_sel != 2'b00) begin
                    sdram_mem[sdr_addr] = word;
                end
                sdr_dout = word;
                sdr_ack  = sdr_req;
            end
        end
    end

    // ========================================
    // Checks and bus tasks
    // ========================================
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks_run++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            OP_MEM_RD: return "mem read";
            OP_MEM_WR: return "mem write";
            OP_IO_RD:  return "io read";
            default:   return "io write";
        endcase
    endfunction

    task automatic add_row(input logic [1:0] kind, input m72_bus_pkg::cpu_addr_t addr,
                           input m72_bus_pkg::cpu_data_t data, input m72_bus_pkg::byte_sel_t sel,
                           input m72_bus_pkg::sdr_addr_t word, input logic [1:0] reqs,
                           input m72_bus_pkg::cpu_data_t exp_val);
        table_rows[rows_loaded] = {kind, addr, data, sel, word, reqs, exp_val};
        rows_loaded++;
    endtask

    // Write rows expect the stored SDRAM word, I/O writes expect {coins, blank, flip}
    task automatic load_table();
        add_row(OP_MEM_WR, 20'hA1230, 16'hBEEF, 2'b11, m72_bus_pkg::RAM_BASE + 25'h0918, 2'd1,
                16'hBEEF);
        add_row(OP_MEM_RD, 20'hA1230, 16'h0000, 2'b11, m72_bus_pkg::RAM_BASE + 25'h0918, 2'd1,
                16'hBEEF);
        add_row(OP_MEM_WR, 20'hA2000, 16'h1234, 2'b11, m72_bus_pkg::RAM_BASE + 25'h1000, 2'd1,
                16'h1234);
        // Odd byte write lands in the high half of the word
        add_row(OP_MEM_WR, 20'hA2001, 16'h00C3, 2'b01, m72_bus_pkg::RAM_BASE + 25'h1000, 2'd1,
                16'hC334);
        add_row(OP_MEM_RD, 20'hA2001, 16'h0000, 2'b01, m72_bus_pkg::RAM_BASE + 25'h1000, 2'd1,
                16'h00C3);
        add_row(OP_MEM_RD, 20'hA2000, 16'h0000, 2'b11, m72_bus_pkg::RAM_BASE + 25'h1000, 2'd1,
                16'hC334);
        add_row(OP_MEM_WR, 20'h01234, 16'hDEAD, 2'b11, m72_bus_pkg::ROM_BASE + 25'h091A, 2'd1,
                fill_word(m72_bus_pkg::ROM_BASE + 25'h091A));
        add_row(OP_MEM_RD, 20'h01234, 16'h0000, 2'b11, m72_bus_pkg::ROM_BASE + 25'h091A, 2'd1,
                fill_word(m72_bus_pkg::ROM_BASE + 25'h091A));
        add_row(OP_MEM_RD, 20'hC0000, 16'h0000, 2'b11, 25'd0, 2'd0, m72_bus_pkg::OPEN_BUS);
        add_row(OP_MEM_RD, 20'h7FFFE, 16'h0000, 2'b11, m72_bus_pkg::ROM_BASE + 25'h3FFFF, 2'd1,
                fill_word(m72_bus_pkg::ROM_BASE + 25'h3FFFF));
        add_row(OP_MEM_WR, 20'hAFFFE, 16'h5AA5, 2'b11, m72_bus_pkg::RAM_BASE + 25'h7FFF, 2'd1,
                16'h5AA5);
        add_row(OP_MEM_RD, 20'hAFFFE, 16'h0000, 2'b11, m72_bus_pkg::RAM_BASE + 25'h7FFF, 2'd1,
                16'h5AA5);
        add_row(OP_IO_RD, 20'h00000, 16'h0000, 2'b00, 25'd0, 2'd0, 16'h0096);
        add_row(OP_IO_RD, 20'h00001, 16'h0000, 2'b00, 25'd0, 2'd0, 16'h003C);
        add_row(OP_IO_RD, 20'h00002, 16'h0000, 2'b00, 25'd0, 2'd0, 16'h00F9);
        add_row(OP_IO_RD, 20'h00003, 16'h0000, 2'b00, 25'd0, 2'd0, 16'h00FF);
        add_row(OP_IO_RD, 20'h00004, 16'h0000, 2'b00, 25'd0, 2'd0, 16'h00E7);
        add_row(OP_IO_RD, 20'h00007, 16'h0000, 2'b00, 25'd0, 2'd0, 16'h00FF);
        add_row(OP_IO_WR, 20'h00002, 16'h000B, 2'b00, 25'd0, 2'd0, 16'h000E);
        add_row(OP_IO_WR, 20'h00002, 16'h0004, 2'b00, 25'd0, 2'd0, 16'h0001);
        add_row(OP_IO_WR, 20'h00006, 16'h00FF, 2'b00, 25'd0, 2'd0, 16'h0001);
    endtask

    task automatic run_mem_op(input row_t r, output m72_bus_pkg::cpu_data_t got);
        @(posedge CLK_32M);
        #1;
        mem.addr  = r.addr;
        mem.data  = r.data;
        mem.sel   = r.sel;
        mem.read  = (r.kind == OP_MEM_RD);
        mem.write = (r.kind == OP_MEM_WR);
        // Captured at the next edge, issued to SDRAM at the one after
        repeat (2) @(posedge CLK_32M);
        @(negedge CLK_32M);
        while (sdr_req != sdr_ack) begin
            @(negedge CLK_32M);
        end
        // First CPU step after the data is back ends the cycle
        @(negedge CLK_32M);
        while (!cpu_ce) begin
            @(negedge CLK_32M);
        end
        got = mem_din;
        @(posedge CLK_32M);
        #1;
        mem.read  = 1'b0;
        mem.write = 1'b0;
    endtask

    task automatic run_io_op(input row_t r, output m72_bus_pkg::cpu_data_t got);
        @(posedge CLK_32M);
        #1;
        io.io_addr  = r.addr[7:0];
        io.io_dout  = r.data[7:0];
        io.io_read  = (r.kind == OP_IO_RD);
        io.io_write = (r.kind == OP_IO_WR);
        if (r.kind == OP_IO_WR) begin
            @(posedge CLK_32M);
            #1;
            io.io_write = 1'b0;
        end
        @(negedge CLK_32M);
        if (r.kind == OP_IO_RD) begin
            got = {8'h00, io_din};
        end else begin
            got = {12'h000, coin_count, video_blank, flip};
        end
        @(posedge CLK_32M);
        #1;
        io.io_read = 1'b0;
    endtask

    task automatic check_idle_enables();
        int last_pulse;
        int pulses;
        last_pulse = -1;
        pulses     = 0;
        for (int cyc = 0; cyc < IDLE_CLKS; cyc++) begin
            @(negedge CLK_32M);
            check_value(32'(cpu_ce_4x), 32'd1, "cpu_ce_4x low without traffic");
            if (cpu_ce) begin
                if (last_pulse >= 0) begin
                    check_value(32'(cyc - last_pulse), 32'd4, "cpu_ce pulse spacing");
                end
                last_pulse = cyc;
                pulses++;
            end
        end
        check_value(32'(pulses), 32'(IDLE_CLKS / 4), "cpu_ce pulse count without traffic");
    endtask

    // Software flip is off after the last flags write, so flip is DIP bit 8 alone
    task automatic check_flip_follows_dip();
        @(posedge CLK_32M);
        #1;
        dip_sw[8] = 1'b0;
        @(negedge CLK_32M);
        check_value(32'(flip), 32'd0, "flip with DIP bit 8 clear");
        @(posedge CLK_32M);
        #1;
        dip_sw = DIP_SW;
    endtask

    // A CPU step while a request is outstanding would lose the access
    always @(negedge CLK_32M) begin
        if (reset_n && sdr_req != sdr_ack) begin
            check_value(32'(cpu_ce), 32'd0, "cpu_ce pulsed during an SDRAM access");
        end
    end

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin : main
        row_t                   r;
        m72_bus_pkg::cpu_data_t got;
        int                     row_errors;
        int                     reqs_before;
        mem      = '0;
        io       = '0;
        dip_sw   = DIP_SW;
        sdr_dout = '0;
        sdr_ack  = 1'b0;
        load_table();
        repeat (2) @(posedge CLK_32M);
        @(negedge CLK_32M);
        check_value(32'({sdr_req, cpu_ce, cpu_ce_4x, coin_count, video_blank}), 32'd0,
                    "outputs not cleared by reset");
        @(posedge reset_n);
        repeat (2) @(posedge CLK_32M);
        row_errors = errors;
        check_idle_enables();
        $display("idle clock enables: %s", (errors == row_errors) ? "ok" : "mismatch");
        for (int i = 0; i < NUM_ROWS; i++) begin
            r           = table_rows[i];
            row_errors  = errors;
            reqs_before = req_count;
            if (r.kind == OP_MEM_RD || r.kind == OP_MEM_WR) begin
                run_mem_op(r, got);
                check_value(32'(req_count - reqs_before), 32'(r.reqs), "SDRAM request count");
                if (r.kind == OP_MEM_WR) begin
                    got = model_word(r.word);
                end
            end else begin
                run_io_op(r, got);
            end
            check_value(32'(got), 32'(r.exp_val), {kind_name(r.kind), " result"});
            $display("row %0d %s at %h: %s", i, kind_name(r.kind), r.addr,
                     (errors == row_errors) ? "ok" : "mismatch");
        end
        row_errors = errors;
        check_flip_follows_dip();
        $display("flip with DIP bit 8 clear: %s", (errors == row_errors) ? "ok" : "mismatch");
        $display("%0d tests, %0d checks, %0d failed", NUM_ROWS + 2, checks_run, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CLKS * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d clocks, a bus operation never completed",
                 WATCHDOG_CLKS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
